//--- common/exec_pkg.sv
// ---------------------------------------------------------------------
// execution package: widths, multiply latency, APB address map,
// instruction field positions and the opcode and controller enums
// ---------------------------------------------------------------------
package exec_pkg;

  // register file
  localparam int data_width_lp   = 32;
  localparam int reg_count_lp    = 32;
  localparam int reg_id_width_lp = 5;

  // cycles from multiply issue to writeback
  localparam int mul_latency_lp  = 4;
  localparam int timer_width_lp  = $clog2(mul_latency_lp);
  localparam logic [timer_width_lp-1:0] timer_load_lp = timer_width_lp'(mul_latency_lp - 1);

  // APB map, one issue word and a read window of one word per register
  localparam int addr_width_lp = 12;
  localparam logic [addr_width_lp-1:0] issue_addr_lp    = 12'h000;
  localparam logic [addr_width_lp-1:0] reg_base_addr_lp = 12'h100;

  // instruction word fields
  localparam int opcode_msb_lp = 31;
  localparam int opcode_lsb_lp = 28;
  localparam int rd_msb_lp     = 27;
  localparam int rd_lsb_lp     = 23;
  localparam int rs1_msb_lp    = 22;
  localparam int rs1_lsb_lp    = 18;
  localparam int rs2_msb_lp    = 17;
  localparam int rs2_lsb_lp    = 13;
  localparam int imm_msb_lp    = 12;
  localparam int imm_lsb_lp    = 0;

  typedef enum logic [3:0] {
    op_nop = 4'h0,
    op_li  = 4'h1,
    op_add = 4'h2,
    op_mul = 4'h3
  } opcode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_check,
    st_issue,
    st_resp
  } ctrl_state_e;

endpackage

//--- scoreboard/scoreboard.sv
// ---------------------------------------------------------------------
// scoreboard: one pending-write bit per register, flags hazards on
// sources and destination with a bypass for a same-cycle clear
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module scoreboard (
    input                                  clk_i
  , input                                  reset_i

  , input  [exec_pkg::reg_id_width_lp-1:0] src1_id_i
  , input  [exec_pkg::reg_id_width_lp-1:0] src2_id_i
  , input  [exec_pkg::reg_id_width_lp-1:0] dest_id_i

  , input                                  op_reads_rf1_i
  , input                                  op_reads_rf2_i
  , input                                  op_writes_rf_i

  , input                                  score_i
  , input                                  clear_i
  , input  [exec_pkg::reg_id_width_lp-1:0] clear_id_i

  , output logic                           dependency_o
);

  logic [exec_pkg::reg_count_lp-1:0] pending_r;
  logic [exec_pkg::reg_count_lp-1:0] pending_n;
  logic [exec_pkg::reg_count_lp-1:0] score_en;
  logic [exec_pkg::reg_count_lp-1:0] clear_en;
  logic                              src1_dep;
  logic                              src2_dep;
  logic                              dest_dep;

  // one-hot targets of score and clear
  always_comb begin
    score_en = '0;
    clear_en = '0;
    score_en[dest_id_i]  = score_i;
    clear_en[clear_id_i] = clear_i;
  end

  // score wins over clear, x0 can never be pending
  always_comb begin
    pending_n    = (pending_r & ~clear_en) | score_en;
    pending_n[0] = 1'b0;
  end

  // a register cleared this cycle is already in the register file
  assign src1_dep = op_reads_rf1_i & pending_r[src1_id_i] & ~clear_en[src1_id_i];
  assign src2_dep = op_reads_rf2_i & pending_r[src2_id_i] & ~clear_en[src2_id_i];
  assign dest_dep = op_writes_rf_i & pending_r[dest_id_i] & ~clear_en[dest_id_i];

  assign dependency_o = src1_dep | src2_dep | dest_dep;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= '0;
    end else begin
      pending_r <= pending_n;
    end
  end

  // the controller holds a new multiply until the previous writeback is gone
  a_score_clear_apart: assert property (
    @(posedge clk_i) disable iff (reset_i) (score_en & clear_en) == '0
  ) else $error("scoreboard: score and clear hit the same register");

endmodule

//--- source/latency_timer.sv
// ---------------------------------------------------------------------
// latency timer: counts down the multiply latency and pulses done
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module latency_timer (
    input        clk_i
  , input        reset_i
  , input        start_i
  , output logic busy_o
  , output logic done_o
);

  logic [exec_pkg::timer_width_lp-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (start_i) begin
      count_r <= exec_pkg::timer_load_lp;
    end else if (count_r != '0) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign busy_o = (count_r != '0);
  // last count, latency minus one cycles after start
  assign done_o = (count_r == exec_pkg::timer_width_lp'(1));

  a_no_restart: assert property (
    @(posedge clk_i) disable iff (reset_i) start_i |-> !busy_o
  ) else $error("latency_timer: start while busy");

endmodule

//--- source/mul_unit.sv
// ---------------------------------------------------------------------
// multiply unit: holds product and destination tag for the fixed
// latency, then presents a one-cycle writeback
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module mul_unit (
    input                                        clk_i
  , input                                        reset_i
  , input                                        start_i
  , input        [exec_pkg::data_width_lp-1:0]   op_a_i
  , input        [exec_pkg::data_width_lp-1:0]   op_b_i
  , input        [exec_pkg::reg_id_width_lp-1:0] dest_id_i

  , output logic                                 busy_o
  , output logic                                 wb_valid_o
  , output logic [exec_pkg::reg_id_width_lp-1:0] wb_id_o
  , output logic [exec_pkg::data_width_lp-1:0]   wb_data_o
);

  logic                                 timer_busy;
  logic                                 timer_done;
  logic                                 wb_valid_r;
  logic [exec_pkg::reg_id_width_lp-1:0] wb_id_r;
  logic [exec_pkg::data_width_lp-1:0]   product_r;

  latency_timer timer (
      .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .start_i (start_i)
    , .busy_o  (timer_busy)
    , .done_o  (timer_done)
  );

  // low half of the product only
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      product_r <= op_a_i * op_b_i;
      wb_id_r   <= dest_id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_r <= 1'b0;
    end else begin
      wb_valid_r <= timer_done;
    end
  end

  assign busy_o     = start_i | timer_busy | wb_valid_r;
  assign wb_valid_o = wb_valid_r;
  assign wb_id_o    = wb_id_r;
  assign wb_data_o  = product_r;

  a_wb_latency: assert property (
    @(posedge clk_i) disable iff (reset_i)
    start_i |-> ##(exec_pkg::mul_latency_lp) (wb_valid_o && $past(wb_valid_o) == 1'b0)
  ) else $error("mul_unit: writeback missed its latency");

endmodule

//--- source/reg_file.sv
// ---------------------------------------------------------------------
// register file: 32 by 32 bits, two read and two write ports,
// reads see same-cycle writes, x0 reads zero
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module reg_file (
    input                                        clk_i
  , input                                        reset_i

  , input        [exec_pkg::reg_id_width_lp-1:0] rd_id_a_i
  , input        [exec_pkg::reg_id_width_lp-1:0] rd_id_b_i
  , output logic [exec_pkg::data_width_lp-1:0]   rd_data_a_o
  , output logic [exec_pkg::data_width_lp-1:0]   rd_data_b_o

  , input                                        we_a_i
  , input        [exec_pkg::reg_id_width_lp-1:0] wr_id_a_i
  , input        [exec_pkg::data_width_lp-1:0]   wr_data_a_i

  , input                                        we_b_i
  , input        [exec_pkg::reg_id_width_lp-1:0] wr_id_b_i
  , input        [exec_pkg::data_width_lp-1:0]   wr_data_b_i
);

  logic [exec_pkg::data_width_lp-1:0] regs_r [1:exec_pkg::reg_count_lp-1];

  function automatic logic [exec_pkg::data_width_lp-1:0] read_reg(
    input logic [exec_pkg::reg_id_width_lp-1:0] id
  );
    logic [exec_pkg::data_width_lp-1:0] value;
    if (id == '0) begin
      value = '0;
    end else if (we_b_i && wr_id_b_i == id) begin
      value = wr_data_b_i;
    end else if (we_a_i && wr_id_a_i == id) begin
      value = wr_data_a_i;
    end else begin
      value = regs_r[id];
    end
    return value;
  endfunction

  always_comb begin
    rd_data_a_o = read_reg(rd_id_a_i);
    rd_data_b_o = read_reg(rd_id_b_i);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < exec_pkg::reg_count_lp; i++) begin
        regs_r[i] <= '0;
      end
    end else begin
      if (we_a_i && wr_id_a_i != '0) begin
        regs_r[wr_id_a_i] <= wr_data_a_i;
      end
      if (we_b_i && wr_id_b_i != '0) begin
        regs_r[wr_id_b_i] <= wr_data_b_i;
      end
    end
  end

  // the ALU never targets a register with a multiply in flight
  a_no_dual_write: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(we_a_i && we_b_i && wr_id_a_i == wr_id_b_i && wr_id_a_i != '0)
  ) else $error("reg_file: both write ports hit register %0d", wr_id_a_i);

endmodule

//--- source/issue_ctrl.sv
// ---------------------------------------------------------------------
// issue controller: APB slave that decodes operations, waits out
// scoreboard hazards, issues to ALU or multiplier and serves reads
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module issue_ctrl (
    input                                        clk_i
  , input                                        reset_i

  , input                                        psel_i
  , input                                        penable_i
  , input                                        pwrite_i
  , input        [exec_pkg::addr_width_lp-1:0]   paddr_i
  , input        [exec_pkg::data_width_lp-1:0]   pwdata_i
  , output logic [exec_pkg::data_width_lp-1:0]   prdata_o
  , output logic                                 pready_o
  , output logic                                 pslverr_o

  , output logic [exec_pkg::reg_id_width_lp-1:0] src1_id_o
  , output logic [exec_pkg::reg_id_width_lp-1:0] src2_id_o
  , output logic [exec_pkg::reg_id_width_lp-1:0] dest_id_o
  , output logic                                 op_reads_rf1_o
  , output logic                                 op_reads_rf2_o
  , output logic                                 op_writes_rf_o
  , output logic                                 score_o
  , input                                        dependency_i

  , output logic [exec_pkg::reg_id_width_lp-1:0] rd_id_a_o
  , output logic [exec_pkg::reg_id_width_lp-1:0] rd_id_b_o
  , input        [exec_pkg::data_width_lp-1:0]   rd_data_a_i
  , input        [exec_pkg::data_width_lp-1:0]   rd_data_b_i

  , output logic                                 alu_we_o
  , output logic [exec_pkg::reg_id_width_lp-1:0] alu_id_o
  , output logic [exec_pkg::data_width_lp-1:0]   alu_data_o

  , output logic                                 mul_start_o
  , output logic [exec_pkg::data_width_lp-1:0]   mul_a_o
  , output logic [exec_pkg::data_width_lp-1:0]   mul_b_o
  , output logic [exec_pkg::reg_id_width_lp-1:0] mul_dest_o
  , input                                        mul_busy_i
);

  exec_pkg::ctrl_state_e state_r;
  exec_pkg::ctrl_state_e state_n;
  exec_pkg::opcode_e     opcode;

  logic [exec_pkg::addr_width_lp-1:0] addr_r;
  logic                               write_r;
  logic [exec_pkg::data_width_lp-1:0] word_r;
  logic [exec_pkg::data_width_lp-1:0] prdata_r;
  logic [exec_pkg::data_width_lp-1:0] imm_ext;
  logic [exec_pkg::reg_id_width_lp-1:0] read_id;
  logic legal_op;
  logic is_issue;
  logic is_read;
  logic is_li;
  logic is_add;
  logic is_mul;
  logic err;
  logic stall;

  // decode of the captured transfer
  always_comb begin
    opcode   = exec_pkg::opcode_e'(word_r[exec_pkg::opcode_msb_lp:exec_pkg::opcode_lsb_lp]);
    legal_op = 1'b0;
    case (opcode)
      exec_pkg::op_nop, exec_pkg::op_li, exec_pkg::op_add, exec_pkg::op_mul:
        legal_op = 1'b1;
      default:
        legal_op = 1'b0;
    endcase
    imm_ext = '0;
    imm_ext[exec_pkg::imm_msb_lp:exec_pkg::imm_lsb_lp] =
      word_r[exec_pkg::imm_msb_lp:exec_pkg::imm_lsb_lp];
  end

  assign is_issue = write_r && (addr_r == exec_pkg::issue_addr_lp);
  // read window is aligned to its own size, so the upper bits select it
  assign is_read  = !write_r && (addr_r[1:0] == 2'b00)
                 && (addr_r[exec_pkg::addr_width_lp-1:exec_pkg::reg_id_width_lp+2]
                     == exec_pkg::reg_base_addr_lp[exec_pkg::addr_width_lp-1:
                                                   exec_pkg::reg_id_width_lp+2]);
  assign read_id  = addr_r[exec_pkg::reg_id_width_lp+1:2];
  assign err      = is_issue ? !legal_op : !is_read;

  assign is_li  = is_issue && (opcode == exec_pkg::op_li);
  assign is_add = is_issue && (opcode == exec_pkg::op_add);
  assign is_mul = is_issue && (opcode == exec_pkg::op_mul);

  // a register read is checked as source 1
  assign src1_id_o      = is_read ? read_id : word_r[exec_pkg::rs1_msb_lp:exec_pkg::rs1_lsb_lp];
  assign src2_id_o      = word_r[exec_pkg::rs2_msb_lp:exec_pkg::rs2_lsb_lp];
  assign dest_id_o      = word_r[exec_pkg::rd_msb_lp:exec_pkg::rd_lsb_lp];
  assign op_reads_rf1_o = is_read || is_add || is_mul;
  assign op_reads_rf2_o = is_add || is_mul;
  assign op_writes_rf_o = is_li || is_add || is_mul;

  assign rd_id_a_o = src1_id_o;
  assign rd_id_b_o = src2_id_o;

  // erroneous transfers skip the hazard wait
  assign stall = !err && (dependency_i || (is_mul && mul_busy_i));

  always_comb begin
    state_n = state_r;
    case (state_r)
      exec_pkg::st_idle:  if (psel_i && penable_i) state_n = exec_pkg::st_check;
      exec_pkg::st_check: if (!stall) state_n = exec_pkg::st_issue;
      exec_pkg::st_issue: state_n = exec_pkg::st_resp;
      default:            state_n = exec_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= exec_pkg::st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == exec_pkg::st_idle && psel_i && penable_i) begin
      addr_r  <= paddr_i;
      write_r <= pwrite_i;
      word_r  <= pwdata_i;
    end
    if (state_r == exec_pkg::st_issue) begin
      prdata_r <= is_read ? rd_data_a_i : '0;
    end
  end

  assign alu_we_o   = (state_r == exec_pkg::st_issue) && (is_li || is_add);
  assign alu_id_o   = dest_id_o;
  assign alu_data_o = is_li ? imm_ext : rd_data_a_i + rd_data_b_i;

  assign mul_start_o = (state_r == exec_pkg::st_issue) && is_mul;
  assign score_o     = mul_start_o;
  assign mul_a_o     = rd_data_a_i;
  assign mul_b_o     = rd_data_b_i;
  assign mul_dest_o  = dest_id_o;

  assign pready_o  = (state_r == exec_pkg::st_resp);
  assign pslverr_o = pready_o && err;
  assign prdata_o  = prdata_r;

  // the host must hold a stalled access phase
  a_apb_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (psel_i && penable_i && !pready_o) |=>
      (psel_i && penable_i && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
  ) else $error("issue_ctrl: APB transfer changed before pready");

  // a hazard passed in st_check must not reopen by the issue cycle
  a_issue_no_hazard: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_r == exec_pkg::st_issue && !err) |-> !dependency_i
  ) else $error("issue_ctrl: operation issued with an open hazard");

endmodule

//--- source/exec_top.sv
// ---------------------------------------------------------------------
// execution top: APB issue controller, scoreboard, register file
// and multiply unit
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module exec_top (
    input                                        clk_i
  , input                                        reset_i

  , input                                        psel_i
  , input                                        penable_i
  , input                                        pwrite_i
  , input        [exec_pkg::addr_width_lp-1:0]   paddr_i
  , input        [exec_pkg::data_width_lp-1:0]   pwdata_i
  , output logic [exec_pkg::data_width_lp-1:0]   prdata_o
  , output logic                                 pready_o
  , output logic                                 pslverr_o
);

  logic [exec_pkg::reg_id_width_lp-1:0] src1_id;
  logic [exec_pkg::reg_id_width_lp-1:0] src2_id;
  logic [exec_pkg::reg_id_width_lp-1:0] dest_id;
  logic                                 op_reads_rf1;
  logic                                 op_reads_rf2;
  logic                                 op_writes_rf;
  logic                                 score;
  logic                                 dependency;

  logic [exec_pkg::reg_id_width_lp-1:0] rd_id_a;
  logic [exec_pkg::reg_id_width_lp-1:0] rd_id_b;
  logic [exec_pkg::data_width_lp-1:0]   rd_data_a;
  logic [exec_pkg::data_width_lp-1:0]   rd_data_b;

  logic                                 alu_we;
  logic [exec_pkg::reg_id_width_lp-1:0] alu_id;
  logic [exec_pkg::data_width_lp-1:0]   alu_data;

  logic                                 mul_start;
  logic [exec_pkg::data_width_lp-1:0]   mul_a;
  logic [exec_pkg::data_width_lp-1:0]   mul_b;
  logic [exec_pkg::reg_id_width_lp-1:0] mul_dest;
  logic                                 mul_busy;

  // multiply writeback, also the scoreboard clear
  logic                                 wb_valid;
  logic [exec_pkg::reg_id_width_lp-1:0] wb_id;
  logic [exec_pkg::data_width_lp-1:0]   wb_data;

  issue_ctrl ctrl (
      .clk_i          (clk_i)
    , .reset_i        (reset_i)
    , .psel_i         (psel_i)
    , .penable_i      (penable_i)
    , .pwrite_i       (pwrite_i)
    , .paddr_i        (paddr_i)
    , .pwdata_i       (pwdata_i)
    , .prdata_o       (prdata_o)
    , .pready_o       (pready_o)
    , .pslverr_o      (pslverr_o)
    , .src1_id_o      (src1_id)
    , .src2_id_o      (src2_id)
    , .dest_id_o      (dest_id)
    , .op_reads_rf1_o (op_reads_rf1)
    , .op_reads_rf2_o (op_reads_rf2)
    , .op_writes_rf_o (op_writes_rf)
    , .score_o        (score)
    , .dependency_i   (dependency)
    , .rd_id_a_o      (rd_id_a)
    , .rd_id_b_o      (rd_id_b)
    , .rd_data_a_i    (rd_data_a)
    , .rd_data_b_i    (rd_data_b)
    , .alu_we_o       (alu_we)
    , .alu_id_o       (alu_id)
    , .alu_data_o     (alu_data)
    , .mul_start_o    (mul_start)
    , .mul_a_o        (mul_a)
    , .mul_b_o        (mul_b)
    , .mul_dest_o     (mul_dest)
    , .mul_busy_i     (mul_busy)
  );

  scoreboard sb (
      .clk_i          (clk_i)
    , .reset_i        (reset_i)
    , .src1_id_i      (src1_id)
    , .src2_id_i      (src2_id)
    , .dest_id_i      (dest_id)
    , .op_reads_rf1_i (op_reads_rf1)
    , .op_reads_rf2_i (op_reads_rf2)
    , .op_writes_rf_i (op_writes_rf)
    , .score_i        (score)
    , .clear_i        (wb_valid)
    , .clear_id_i     (wb_id)
    , .dependency_o   (dependency)
  );

  reg_file rf (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .rd_id_a_i   (rd_id_a)
    , .rd_id_b_i   (rd_id_b)
    , .rd_data_a_o (rd_data_a)
    , .rd_data_b_o (rd_data_b)
    , .we_a_i      (alu_we)
    , .wr_id_a_i   (alu_id)
    , .wr_data_a_i (alu_data)
    , .we_b_i      (wb_valid)
    , .wr_id_b_i   (wb_id)
    , .wr_data_b_i (wb_data)
  );

  mul_unit mul (
      .clk_i      (clk_i)
    , .reset_i    (reset_i)
    , .start_i    (mul_start)
    , .op_a_i     (mul_a)
    , .op_b_i     (mul_b)
    , .dest_id_i  (mul_dest)
    , .busy_o     (mul_busy)
    , .wb_valid_o (wb_valid)
    , .wb_id_o    (wb_id)
    , .wb_data_o  (wb_data)
  );

endmodule

//--- test/clock_gen.sv
// ---------------------------------------------------------------------
// testbench clock and reset: 40 ns clock, reset held for 4 cycles
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module clock_gen (
    output logic clk_o
  , output logic reset_o
);

  localparam int half_period_lp  = 20;
  localparam int reset_cycles_lp = 4;
  localparam int drive_delay_lp  = 2;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_period_lp);
      clk_o = ~clk_o;
    end
  end

  // released shortly after an edge, like every other driven input
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_lp) @(posedge clk_o);
    #(drive_delay_lp);
    reset_o = 1'b0;
  end

endmodule

//--- test/tb_exec.sv
// ---------------------------------------------------------------------
// testbench for the execution subsystem: runs APB transfers from the
// stimulus file and compares read data and error flags
// ---------------------------------------------------------------------
`timescale 1ns/100ps

module tb_exec;

  localparam int timeout_cycles_lp = 200;
  localparam int drive_delay_lp    = 2;
  localparam logic [exec_pkg::addr_width_lp-1:0] unmapped_base_lp = 12'h200;

  logic                               clk;
  logic                               reset;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [exec_pkg::addr_width_lp-1:0] paddr;
  logic [exec_pkg::data_width_lp-1:0] pwdata;
  logic [exec_pkg::data_width_lp-1:0] prdata;
  logic                               pready;
  logic                               pslverr;

  int error_count;
  int timeout_count;

  clock_gen clk_gen (
      .clk_o   (clk)
    , .reset_o (reset)
  );

  exec_top dut (
      .clk_i     (clk)
    , .reset_i   (reset)
    , .psel_i    (psel)
    , .penable_i (penable)
    , .pwrite_i  (pwrite)
    , .paddr_i   (paddr)
    , .pwdata_i  (pwdata)
    , .prdata_o  (prdata)
    , .pready_o  (pready)
    , .pslverr_o (pslverr)
  );

  task automatic check_data(
    input string                              name,
    input logic [exec_pkg::data_width_lp-1:0] expected,
    input logic [exec_pkg::data_width_lp-1:0] actual
  );
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s: data expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_err(
    input string name,
    input logic  expected,
    input logic  actual
  );
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s: pslverr expected %b, actual %b", name, expected, actual);
    end
  endtask

  function automatic logic [3:0] opcode_from_name(input string opname);
    logic [3:0] code;
    if (opname == "nop") begin
      code = exec_pkg::op_nop;
    end else if (opname == "li") begin
      code = exec_pkg::op_li;
    end else if (opname == "add") begin
      code = exec_pkg::op_add;
    end else if (opname == "mul") begin
      code = exec_pkg::op_mul;
    end else begin
      // outside opcode_e, so the DUT must reject it
      code = 4'hf;
    end
    return code;
  endfunction

  function automatic logic [exec_pkg::data_width_lp-1:0] encode_op(
    input logic [3:0]                           op,
    input logic [exec_pkg::reg_id_width_lp-1:0] rd,
    input logic [exec_pkg::reg_id_width_lp-1:0] rs1,
    input logic [exec_pkg::reg_id_width_lp-1:0] rs2,
    input logic [exec_pkg::data_width_lp-1:0]   imm
  );
    logic [exec_pkg::data_width_lp-1:0] word;
    word = '0;
    word[exec_pkg::opcode_msb_lp:exec_pkg::opcode_lsb_lp] = op;
    word[exec_pkg::rd_msb_lp:exec_pkg::rd_lsb_lp]         = rd;
    word[exec_pkg::rs1_msb_lp:exec_pkg::rs1_lsb_lp]       = rs1;
    word[exec_pkg::rs2_msb_lp:exec_pkg::rs2_lsb_lp]       = rs2;
    word[exec_pkg::imm_msb_lp:exec_pkg::imm_lsb_lp] =
      imm[exec_pkg::imm_msb_lp-exec_pkg::imm_lsb_lp:0];
    return word;
  endfunction

  // setup phase, access phase, then hold until pready
  // starts at the drive point so that transfers can run back to back
  task automatic apb_transfer(
    input  logic                               write,
    input  logic [exec_pkg::addr_width_lp-1:0] addr,
    input  logic [exec_pkg::data_width_lp-1:0] wdata,
    output logic [exec_pkg::data_width_lp-1:0] rdata,
    output logic                               err,
    output logic                               timed_out
  );
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #(drive_delay_lp);
    penable = 1'b1;
    // outputs are sampled mid-cycle where they are settled
    while (!done && waited < timeout_cycles_lp) begin
      @(negedge clk);
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        waited++;
      end
    end
    timed_out = !done;
    @(posedge clk);
    #(drive_delay_lp);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_test(
    input  string                                name,
    input  string                                kind,
    input  string                                opname,
    input  logic [exec_pkg::reg_id_width_lp-1:0] rd,
    input  logic [exec_pkg::reg_id_width_lp-1:0] rs1,
    input  logic [exec_pkg::reg_id_width_lp-1:0] rs2,
    input  logic [exec_pkg::data_width_lp-1:0]   imm,
    input  logic [exec_pkg::data_width_lp-1:0]   exp_data,
    input  logic                                 exp_err,
    output logic                                 timed_out
  );
    logic [exec_pkg::addr_width_lp-1:0] offset;
    logic [exec_pkg::addr_width_lp-1:0] addr;
    logic [exec_pkg::data_width_lp-1:0] word;
    logic [exec_pkg::data_width_lp-1:0] rdata;
    logic                               write;
    logic                               err;
    logic                               known;
    timed_out = 1'b0;
    known     = 1'b1;
    word      = encode_op(opcode_from_name(opname), rd, rs1, rs2, imm);
    // one word per register in the read window
    offset = '0;
    offset[exec_pkg::reg_id_width_lp+1:2] = rd;
    write = 1'b0;
    addr  = '0;
    if (kind == "op") begin
      write = 1'b1;
      addr  = exec_pkg::issue_addr_lp;
    end else if (kind == "read") begin
      addr = exec_pkg::reg_base_addr_lp + offset;
    end else if (kind == "write_win") begin
      write = 1'b1;
      addr  = exec_pkg::reg_base_addr_lp + offset;
    end else if (kind == "read_bad") begin
      addr = unmapped_base_lp + offset;
    end else begin
      known = 1'b0;
      error_count++;
      $display("test %s has an unknown transfer kind %s", name, kind);
    end
    if (known) begin
      apb_transfer(write, addr, word, rdata, err, timed_out);
      if (timed_out) begin
        timeout_count++;
        $display("test %s got no pready within %0d cycles", name, timeout_cycles_lp);
      end else begin
        check_err(name, exp_err, err);
        if (kind == "read") begin
          check_data(name, exp_data, rdata);
        end
      end
    end
  endtask

  task automatic wait_reset_release(output logic timed_out);
    int waited;
    waited = 0;
    while (reset && waited < timeout_cycles_lp) begin
      @(negedge clk);
      waited++;
    end
    timed_out = reset;
  endtask

  task automatic finish_run();
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    int                                 fd;
    int                                 fields;
    int                                 tests_run;
    int                                 exp_err;
    string                              line;
    string                              name;
    string                              kind;
    string                              opname;
    logic [exec_pkg::reg_id_width_lp-1:0] rd;
    logic [exec_pkg::reg_id_width_lp-1:0] rs1;
    logic [exec_pkg::reg_id_width_lp-1:0] rs2;
    logic [exec_pkg::data_width_lp-1:0] imm;
    logic [exec_pkg::data_width_lp-1:0] exp_data;
    logic                               stop;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    error_count   = 0;
    timeout_count = 0;
    tests_run     = 0;
    void'($urandom(32'h952e9dad));
    wait_reset_release(stop);
    if (stop) begin
      timeout_count++;
      $display("reset was never released");
    end
    fd = 0;
    if (!stop) begin
      // move to the drive point after an edge
      @(posedge clk);
      #(drive_delay_lp);
      fd = $fopen("test/exec_stimulus.txt", "r");
      if (fd == 0) begin
        stop = 1'b1;
        error_count++;
        $display("could not open the stimulus file");
      end
    end
    while (!stop && $fgets(line, fd) != 0) begin
      // skip blank lines and column notes
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %s %s %d %d %d %h %h %d",
                         name, kind, opname, rd, rs1, rs2, imm, exp_data, exp_err);
        if (fields != 9) begin
          error_count++;
          $display("malformed stimulus line: %s", line);
        end else begin
          repeat ($urandom % 4) begin
            @(posedge clk);
            #(drive_delay_lp);
          end
          run_test(name, kind, opname, rd, rs1, rs2, imm, exp_data, exp_err[0], stop);
          tests_run++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (fd != 0 && tests_run == 0) begin
      error_count++;
      $display("the stimulus file held no tests");
    end
    finish_run();
  end

endmodule

//--- test/exec_stimulus.txt
# name kind(op|read|write_win|read_bad) opcode rd rs1 rs2 imm(hex) expected_data(hex) pslverr
# expected data is compared on read transfers only
li_x1          op        li   1  0  0  0123  00000000  0
li_x2          op        li   2  0  0  1fff  00000000  0
li_x3          op        li   3  0  0  0007  00000000  0
li_x4          op        li   4  0  0  1000  00000000  0
rd_x1          read      -    1  0  0  0000  00000123  0
rd_x2          read      -    2  0  0  0000  00001fff  0
rd_x3          read      -    3  0  0  0000  00000007  0
rd_x4          read      -    4  0  0  0000  00001000  0
add_x5         op        add  5  1  2  0000  00000000  0
rd_x5          read      -    5  0  0  0000  00002122  0
mul_x8         op        mul  8  2  4  0000  00000000  0
add_x11_dep    op        add  11 8  1  0000  00000000  0
rd_x8          read      -    8  0  0  0000  01fff000  0
mul_x9         op        mul  9  8  4  0000  00000000  0
rd_x9_dep      read      -    9  0  0  0000  ff000000  0
add_x10_wrap   op        add  10 9  9  0000  00000000  0
add_x12_wrap   op        add  12 9  8  0000  00000000  0
rd_x10         read      -    10 0  0  0000  fe000000  0
rd_x11         read      -    11 0  0  0000  01fff123  0
rd_x12         read      -    12 0  0  0000  00fff000  0
mul_x13        op        mul  13 3  4  0000  00000000  0
li_x13_wait    op        li   13 0  0  0055  00000000  0
rd_x13         read      -    13 0  0  0000  00000055  0
mul_x14        op        mul  14 3  3  0000  00000000  0
mul_x14_again  op        mul  14 14 3  0000  00000000  0
mul_x15        op        mul  15 14 2  0000  00000000  0
rd_x14         read      -    14 0  0  0000  00000157  0
rd_x15         read      -    15 0  0  0000  002adea9  0
li_x0          op        li   0  0  0  0abc  00000000  0
mul_x0         op        mul  0  2  3  0000  00000000  0
rd_x0          read      -    0  0  0  0000  00000000  0
add_x16_x0     op        add  16 0  3  0000  00000000  0
rd_x16         read      -    16 0  0  0000  00000007  0
bad_opcode     op        bad  1  0  0  0fff  00000000  1
win_write      write_win li   2  0  0  0abc  00000000  1
unmapped_read  read_bad  -    3  0  0  0000  00000000  1
rd_x1_after    read      -    1  0  0  0000  00000123  0
rd_x2_after    read      -    2  0  0  0000  00001fff  0
rd_x3_after    read      -    3  0  0  0000  00000007  0

//--- project.f
common/exec_pkg.sv
scoreboard/scoreboard.sv
source/latency_timer.sv
source/mul_unit.sv
source/reg_file.sv
source/issue_ctrl.sv
source/exec_top.sv
test/clock_gen.sv
test/tb_exec.sv
